// ==== list.f ====
+incdir+source
+incdir+tb
source/rvj1_pkg.sv
source/rvj1_ctrl.sv
source/rvj1_ifu.sv
source/rvj1_frontend.sv
tb/rvj1_frontend_tb.sv

// ==== run.sh ====
#!/bin/sh
# Build and run the front end testbench with Verilator
cd "$(dirname "$0")" || exit 1

verilator --binary --timing --timescale 1ns/1ps \
  --top-module rvj1_frontend_tb -Mdir obj_dir -f list.f
status=$?
if [ $status -ne 0 ]; then
  echo "Verilator build failed with status $status"
  exit 1
fi

./obj_dir/Vrvj1_frontend_tb
status=$?
if [ $status -ne 0 ]; then
  echo "Simulation ended with status $status"
  exit 1
fi
exit 0

// ==== tb/rvj1_tb_model.svh ====
`ifndef RVJ1_TB_MODEL_SVH
`define RVJ1_TB_MODEL_SVH

// LFSR register, seeded at time zero
logic [31:0]            lfsr_state;

// Model registers, controller side
ctrl_fsm_e              m_state;
branch_ctrl_e           m_btype;
logic [`RVJ1_XLEN-1:0]  m_pc;

// Model registers, fetch side
logic [`RVJ1_XLEN-1:0]  m_faddr;
logic                   m_fen;
logic                   m_pend;
logic                   m_skid_v;
logic [`RVJ1_XLEN-1:0]  m_skid;
logic                   m_instr_v;
logic [`RVJ1_XLEN-1:0]  m_instr;

// Expected combinational values of the current cycle
logic                   e_stall;
logic                   e_req;
logic                   e_redirect;
ctrl_fsm_e              e_next;

////////////////////
// Helpers
////////////////////

// Fibonacci LFSR, taps 32 22 2 1, one step per bit
function automatic logic [31:0] lfsr_take(input int n);
  logic [31:0] bits;
  logic        fb;
  bits = '0;
  for (int i = 0; i < n; i++) begin
    fb         = lfsr_state[31] ^ lfsr_state[21] ^ lfsr_state[1] ^ lfsr_state[0];
    lfsr_state = {lfsr_state[30:0], fb};
    bits       = {bits[30:0], fb};
  end
  return bits;
endfunction

// Memory contents, a rotation of the whole address
function automatic logic [31:0] word_at(input logic [31:0] addr);
  return {addr[7:0], addr[31:8]} ^ 32'h5a5a_0f0f;
endfunction

task automatic check_value(input string name, input logic [31:0] got,
                           input logic [31:0] exp);
  if (got !== exp) begin
    $display("Error: %s is %h, expected %h", name, got, exp);
    $display(">>> FAIL");
    $fatal(1, "Value mismatch on %s", name);
  end
endtask

task automatic reset_model();
  m_state   = CTRL_RESET;
  m_btype   = BRANCH_EQ;
  m_pc      = `RVJ1_BOOT_ADDR;
  m_faddr   = '0;
  m_fen     = 1'b0;
  m_pend    = 1'b0;
  m_skid_v  = 1'b0;
  m_skid    = '0;
  m_instr_v = 1'b0;
  m_instr   = '0;
endtask

////////////////////
// Expected values
////////////////////

task automatic compute_expected();
  logic hz_a;
  logic hz_b;
  logic hz_st;
  logic cond;
  hz_a  = (alu_regdest_r_i == rf_addr_a_i) && !rpa_or_pc_i && (rf_addr_a_i != '0);
  hz_b  = (alu_regdest_r_i == rf_addr_b_i) && !rpb_or_imm_i && (rf_addr_b_i != '0);
  // Store data comes from rb whatever the b operand select says
  hz_st = (alu_regdest_r_i == rf_addr_b_i) && lsu_ctrl_valid_i && lsu_cmd_i[3] &&
          (rf_addr_b_i != '0);
  e_stall = hz_a || hz_b || hz_st ||
            (m_state inside {CTRL_LOAD0, CTRL_LOAD1, CTRL_JUMP0, CTRL_JUMP1});
  // Boot and jump both redirect fetch
  e_redirect = (m_state == CTRL_BOOT0) || (m_state == CTRL_JUMP0);
  e_req      = m_fen && !e_stall && !e_redirect;
  // Condition table, latched type against the ALU result
  case (m_btype)
    BRANCH_EQ:             cond = (alu_res_i == '0);
    BRANCH_NEQ:            cond = (alu_res_i != '0);
    BRANCH_LT, BRANCH_LTU: cond = alu_res_i[0];
    default:               cond = !alu_res_i[0];
  endcase
  e_next = m_state;
  case (m_state)
    CTRL_RESET:             e_next = CTRL_BOOT0;
    CTRL_BOOT0:             e_next = CTRL_BOOT1;
    CTRL_BOOT1, CTRL_JUMP1: e_next = CTRL_RUN;
    CTRL_JUMP0:             e_next = CTRL_JUMP1;
    CTRL_LOAD0:             e_next = CTRL_LOAD1;
    CTRL_LOAD1:             e_next = lsu_ready_i ? CTRL_RUN : CTRL_LOAD1;
    CTRL_BRANCH: begin
      if (!e_stall) e_next = cond ? CTRL_JUMP0 : CTRL_RUN;
    end
    CTRL_RUN: begin
      // Branch first, then jump, then load
      if (!e_stall && ctrl_branch_i) e_next = CTRL_BRANCH;
      else if (!e_stall && ctrl_jump_i) e_next = CTRL_JUMP0;
      else if (!e_stall && lsu_ctrl_valid_i && !lsu_cmd_i[3]) e_next = CTRL_LOAD0;
    end
    default: e_next = CTRL_RESET;
  endcase
endtask

// One rising edge of the model, old values read before they change
task automatic advance_model();
  if (e_next == CTRL_JUMP1) begin
    m_pc = alu_res_i;
  end else if ((m_instr_v && !e_stall) || ctrl_jump_i) begin
    m_pc = m_pc + `RVJ1_ISTEP;
  end
  if (ctrl_branch_i) m_btype = ctrl_branch_type_i;
  // Returned word parks in the skid under stall
  if (m_pend && e_stall) m_skid = imem_rdata_i;
  if (!e_stall && m_skid_v) m_instr = m_skid;
  else if (!e_stall && m_pend) m_instr = imem_rdata_i;
  if (e_redirect) begin
    m_pend    = 1'b0;
    m_skid_v  = 1'b0;
    m_instr_v = 1'b0;
  end else begin
    if (!e_stall) m_instr_v = m_pend || m_skid_v;
    m_skid_v = e_stall ? (m_skid_v || m_pend) : 1'b0;
    m_pend   = e_req;
  end
  // Fetch address, boot vector or jump target with bit 0 cleared
  if (e_redirect) begin
    m_faddr = (m_state == CTRL_JUMP0) ? {alu_res_i[31:1], 1'b0} : `RVJ1_BOOT_ADDR;
    m_fen   = 1'b1;
  end else if (e_req) begin
    m_faddr = m_faddr + `RVJ1_ISTEP;
  end
  m_state = e_next;
endtask

`endif

// ==== tb/rvj1_frontend_tb.sv ====
`timescale 1ns/1ps
`default_nettype none

`include "rvj1_defines.svh"

module rvj1_frontend_tb;
  import rvj1_pkg::*;

  localparam int RESET_CYCLES = 10;
  localparam int TEST_CYCLES  = 2000;
  // Whole run in ns plus a margin
  localparam int WATCHDOG_NS  = (RESET_CYCLES + TEST_CYCLES + 50) * 40;

  logic                   clk_i = 1'b0;
  logic                   rstn_i;
  logic [`RVJ1_RALEN-1:0] rf_addr_a_i;
  logic [`RVJ1_RALEN-1:0] rf_addr_b_i;
  logic                   rpa_or_pc_i;
  logic                   rpb_or_imm_i;
  lsu_ctrl_e              lsu_cmd_i;
  logic                   lsu_ctrl_valid_i;
  logic                   ctrl_jump_i;
  logic                   ctrl_branch_i;
  branch_ctrl_e           ctrl_branch_type_i;
  logic [`RVJ1_RALEN-1:0] alu_regdest_r_i;
  logic [`RVJ1_XLEN-1:0]  alu_res_i;
  logic                   lsu_ready_i;
  logic [`RVJ1_XLEN-1:0]  imem_rdata_i;
  wire  [`RVJ1_XLEN-1:0]  imem_addr_o;
  wire                    imem_req_o;
  wire  [`RVJ1_XLEN-1:0]  instr_o;
  wire                    instr_valid_o;
  wire  [`RVJ1_XLEN-1:0]  program_counter_o;
  wire                    stall_o;
  wire                    flush_o;

  // Legal encodings picked by three random bits
  lsu_ctrl_e    lsu_table [8] = '{LSU_LB, LSU_LH, LSU_LW, LSU_LBU,
                                  LSU_LHU, LSU_SB, LSU_SH, LSU_SW};
  branch_ctrl_e branch_table [8] = '{BRANCH_EQ, BRANCH_NEQ, BRANCH_LT, BRANCH_GE,
                                     BRANCH_LTU, BRANCH_GEU, BRANCH_EQ, BRANCH_NEQ};

  // Last request is answered in the next cycle
  logic                   last_req;
  logic [`RVJ1_XLEN-1:0]  last_addr;
  logic                   boot_seen;

  `include "rvj1_tb_model.svh"

  rvj1_frontend UUT (.*);

  always #20 clk_i = ~clk_i;

  initial begin : watchdog
    #(WATCHDOG_NS);
    $display(">>> FAIL");
    $fatal(1, "Timeout, the test loop did not finish within %0d ns", WATCHDOG_NS);
  end

  // Small register numbers so hazards and x0 come up often
  task automatic drive_stimulus();
    logic run_now;
    run_now            = (m_state == CTRL_RUN);
    rf_addr_a_i        = `RVJ1_RALEN'(lfsr_take(3));
    rf_addr_b_i        = `RVJ1_RALEN'(lfsr_take(3));
    alu_regdest_r_i    = `RVJ1_RALEN'(lfsr_take(3));
    rpa_or_pc_i        = 1'(lfsr_take(1));
    rpb_or_imm_i       = 1'(lfsr_take(1));
    lsu_ctrl_valid_i   = (lfsr_take(3) == 0);
    lsu_cmd_i          = lsu_table[3'(lfsr_take(3))];
    // Ready one cycle in four gives random load lengths
    lsu_ready_i        = (lfsr_take(2) == 0);
    // Zero results often enough for EQ branches
    alu_res_i          = (lfsr_take(2) == 0) ? '0 : lfsr_take(32);
    ctrl_jump_i        = run_now && (lfsr_take(4) == 0);
    ctrl_branch_i      = run_now && (lfsr_take(4) == 0);
    ctrl_branch_type_i = branch_table[3'(lfsr_take(3))];
    // Memory answers the last request and gives noise otherwise
    imem_rdata_i       = last_req ? word_at(last_addr) : lfsr_take(32);
  endtask

  initial begin : stimulus
    lfsr_state         = 32'hc5dc;
    rstn_i             = 1'b0;
    rf_addr_a_i        = '0;
    rf_addr_b_i        = '0;
    rpa_or_pc_i        = 1'b0;
    rpb_or_imm_i       = 1'b0;
    lsu_cmd_i          = LSU_LB;
    lsu_ctrl_valid_i   = 1'b0;
    ctrl_jump_i        = 1'b0;
    ctrl_branch_i      = 1'b0;
    ctrl_branch_type_i = BRANCH_EQ;
    alu_regdest_r_i    = '0;
    alu_res_i          = '0;
    lsu_ready_i        = 1'b0;
    imem_rdata_i       = '0;
    last_req           = 1'b0;
    last_addr          = '0;
    boot_seen          = 1'b0;
    reset_model();
    repeat (RESET_CYCLES) @(negedge clk_i);
    rstn_i = 1'b1;
    check_value("program_counter_o", program_counter_o, `RVJ1_BOOT_ADDR);
    repeat (TEST_CYCLES) begin
      drive_stimulus();
      // Outputs settle well before the next rising edge
      #5;
      compute_expected();
      check_value("stall_o", 32'(stall_o), 32'(e_stall));
      check_value("flush_o", 32'(flush_o), 32'(m_state == CTRL_JUMP0));
      check_value("program_counter_o", program_counter_o, m_pc);
      check_value("imem_req_o", 32'(imem_req_o), 32'(e_req));
      // First fetch after reset goes to the boot vector
      if (imem_req_o && !boot_seen) begin
        check_value("imem_addr_o", imem_addr_o, `RVJ1_BOOT_ADDR);
        boot_seen = 1'b1;
      end
      check_value("imem_addr_o", imem_addr_o, m_faddr);
      check_value("instr_valid_o", 32'(instr_valid_o), 32'(m_instr_v));
      if (m_instr_v) check_value("instr_o", instr_o, m_instr);
      last_req  = imem_req_o;
      last_addr = imem_addr_o;
      advance_model();
      @(negedge clk_i);
    end
    if (boot_seen) begin
      $display(">>> PASS");
      $finish;
    end else begin
      $display("No fetch request was made after reset");
      $display(">>> FAIL");
      $fatal(1, "Fetch never started");
    end
  end

endmodule

`default_nettype wire

// ==== source/rvj1_frontend.sv ====
`timescale 1ns/1ps
`default_nettype none

`include "rvj1_defines.svh"

module rvj1_frontend #(
  parameter logic [`RVJ1_XLEN-1:0] BOOT_ADDR = `RVJ1_BOOT_ADDR
) (
  input  wire                           clk_i,
  input  wire                           rstn_i,

  // Decoded fields
  input  wire  [`RVJ1_RALEN-1:0]        rf_addr_a_i,
  input  wire  [`RVJ1_RALEN-1:0]        rf_addr_b_i,
  input  wire                           rpa_or_pc_i,
  input  wire                           rpb_or_imm_i,
  input  wire  rvj1_pkg::lsu_ctrl_e     lsu_cmd_i,
  input  wire                           lsu_ctrl_valid_i,
  input  wire                           ctrl_jump_i,
  input  wire                           ctrl_branch_i,
  input  wire  rvj1_pkg::branch_ctrl_e  ctrl_branch_type_i,

  // Execute stage and LSU
  input  wire  [`RVJ1_RALEN-1:0]        alu_regdest_r_i,
  input  wire  [`RVJ1_XLEN-1:0]         alu_res_i,
  input  wire                           lsu_ready_i,

  // Instruction memory
  output logic [`RVJ1_XLEN-1:0]         imem_addr_o,
  output logic                          imem_req_o,
  input  wire  [`RVJ1_XLEN-1:0]         imem_rdata_i,

  // To decode
  output logic [`RVJ1_XLEN-1:0]         instr_o,
  output logic                          instr_valid_o,
  output logic [`RVJ1_XLEN-1:0]         program_counter_o,
  output logic                          stall_o,
  output logic                          flush_o
);
  // Redirect and issue handshake between controller and fetch
  logic                   jmp_addr_valid;
  logic [`RVJ1_XLEN-1:0]  jmp_addr;
  logic                   instr_issued;

  rvj1_ctrl #(
    .BOOT_ADDR (BOOT_ADDR)
  ) u_ctrl (
    .clk_i              (clk_i),
    .rstn_i             (rstn_i),
    .rf_addr_a_i        (rf_addr_a_i),
    .rf_addr_b_i        (rf_addr_b_i),
    .rpa_or_pc_i        (rpa_or_pc_i),
    .rpb_or_imm_i       (rpb_or_imm_i),
    .alu_regdest_r_i    (alu_regdest_r_i),
    .lsu_cmd_i          (lsu_cmd_i),
    .lsu_ctrl_valid_i   (lsu_ctrl_valid_i),
    .lsu_ready_i        (lsu_ready_i),
    .ctrl_jump_i        (ctrl_jump_i),
    .alu_res_i          (alu_res_i),
    .ctrl_branch_i      (ctrl_branch_i),
    .ctrl_branch_type_i (ctrl_branch_type_i),
    .instr_issued_i     (instr_issued),
    .stall_o            (stall_o),
    .program_counter_o  (program_counter_o),
    .flush_o            (flush_o),
    .jmp_addr_valid_o   (jmp_addr_valid),
    .jmp_addr_o         (jmp_addr)
  );

  // Fetch follows the controller's stall, flush and redirect
  rvj1_ifu u_ifu (
    .clk_i            (clk_i),
    .rstn_i           (rstn_i),
    .stall_i          (stall_o),
    .flush_i          (flush_o),
    .jmp_addr_valid_i (jmp_addr_valid),
    .jmp_addr_i       (jmp_addr),
    .imem_rdata_i     (imem_rdata_i),
    .imem_addr_o      (imem_addr_o),
    .imem_req_o       (imem_req_o),
    .instr_o          (instr_o),
    .instr_valid_o    (instr_valid_o),
    .instr_issued_o   (instr_issued)
  );

endmodule

`default_nettype wire

// ==== source/rvj1_ifu.sv ====
`timescale 1ns/1ps
`default_nettype none

`include "rvj1_defines.svh"

module rvj1_ifu (
  input  wire                     clk_i,
  input  wire                     rstn_i,
  input  wire                     stall_i,
  input  wire                     flush_i,
  input  wire                     jmp_addr_valid_i,
  input  wire  [`RVJ1_XLEN-1:0]   jmp_addr_i,
  input  wire  [`RVJ1_XLEN-1:0]   imem_rdata_i,
  output logic [`RVJ1_XLEN-1:0]   imem_addr_o,
  output logic                    imem_req_o,
  output logic [`RVJ1_XLEN-1:0]   instr_o,
  output logic                    instr_valid_o,
  output logic                    instr_issued_o
);
  logic [`RVJ1_XLEN-1:0]  fetch_addr_q;
  logic                   fetch_en_q;
  logic                   pend_q;
  logic [`RVJ1_XLEN-1:0]  skid_q;
  logic                   skid_valid_q;
  logic [`RVJ1_XLEN-1:0]  instr_q;
  logic                   instr_valid_q;
  logic                   redirect;

  assign redirect = flush_i || jmp_addr_valid_i;

  // No fetch before the first redirect, none while the address changes
  assign imem_req_o  = fetch_en_q && !stall_i && !redirect;
  assign imem_addr_o = fetch_addr_q;

  ////////////////////
  // Fetch address
  ////////////////////
  always_ff @(posedge clk_i) begin
    if (!rstn_i) begin
      fetch_addr_q <= '0;
      fetch_en_q   <= 1'b0;
    end else if (jmp_addr_valid_i) begin
      fetch_addr_q <= jmp_addr_i;
      fetch_en_q   <= 1'b1;
    end else if (imem_req_o) begin
      fetch_addr_q <= fetch_addr_q + `RVJ1_XLEN'(`RVJ1_ISTEP);
    end
  end

  ////////////////////
  // Response tracking
  ////////////////////
  // One request in flight at most
  // Data returning under stall parks in the skid register
  always_ff @(posedge clk_i) begin
    if (!rstn_i || redirect) begin
      pend_q        <= 1'b0;
      skid_valid_q  <= 1'b0;
      instr_valid_q <= 1'b0;
    end else begin
      pend_q <= imem_req_o;
      if (stall_i) begin
        if (pend_q) skid_valid_q <= 1'b1;
      end else begin
        skid_valid_q  <= 1'b0;
        instr_valid_q <= pend_q || skid_valid_q;
      end
    end
  end

  // Payload, decode copy held under stall
  always_ff @(posedge clk_i) begin
    if (pend_q && stall_i) begin
      skid_q <= imem_rdata_i;
    end
    if (!stall_i) begin
      if (skid_valid_q) begin
        instr_q <= skid_q;
      end else if (pend_q) begin
        instr_q <= imem_rdata_i;
      end
    end
  end

  assign instr_o        = instr_q;
  assign instr_valid_o  = instr_valid_q;
  assign instr_issued_o = instr_valid_q;

endmodule

`default_nettype wire

// ==== source/rvj1_ctrl.sv ====
`timescale 1ns/1ps
`default_nettype none

`include "rvj1_defines.svh"

module rvj1_ctrl #(
  parameter logic [`RVJ1_XLEN-1:0] BOOT_ADDR = `RVJ1_BOOT_ADDR
) (
  input  wire                           clk_i,
  input  wire                           rstn_i,

  // Operand fields of the instruction in decode
  input  wire  [`RVJ1_RALEN-1:0]        rf_addr_a_i,
  input  wire  [`RVJ1_RALEN-1:0]        rf_addr_b_i,
  input  wire                           rpa_or_pc_i,
  input  wire                           rpb_or_imm_i,

  // Destination register held in the ALU stage
  input  wire  [`RVJ1_RALEN-1:0]        alu_regdest_r_i,

  // LSU command and status
  input  wire  rvj1_pkg::lsu_ctrl_e     lsu_cmd_i,
  input  wire                           lsu_ctrl_valid_i,
  input  wire                           lsu_ready_i,

  // Jump and branch control
  input  wire                           ctrl_jump_i,
  input  wire  [`RVJ1_XLEN-1:0]         alu_res_i,
  input  wire                           ctrl_branch_i,
  input  wire  rvj1_pkg::branch_ctrl_e  ctrl_branch_type_i,

  // Fetch side
  input  wire                           instr_issued_i,
  output logic                          stall_o,
  output logic [`RVJ1_XLEN-1:0]         program_counter_o,
  output logic                          flush_o,
  output logic                          jmp_addr_valid_o,
  output logic [`RVJ1_XLEN-1:0]         jmp_addr_o
);
  import rvj1_pkg::*;

  ctrl_fsm_e              state_q;
  ctrl_fsm_e              state_d;
  logic                   rf_a_hazard;
  logic                   rf_b_hazard;
  logic                   lsu_b_hazard;
  logic                   fsm_stall;
  branch_ctrl_e           branch_type_q;
  logic                   cond_met;
  logic [`RVJ1_XLEN-1:0]  pc_q;

  ////////////////////
  // Hazard detection
  ////////////////////

  // Operand a reads the register the ALU is about to write
  assign rf_a_hazard = (alu_regdest_r_i == rf_addr_a_i) && !rpa_or_pc_i &&
                       (rf_addr_a_i != '0);

  // Operand b, unless an immediate takes its place
  assign rf_b_hazard = (alu_regdest_r_i == rf_addr_b_i) && !rpb_or_imm_i &&
                       (rf_addr_b_i != '0);

  // Stores read rb as the data even with an immediate offset
  assign lsu_b_hazard = (alu_regdest_r_i == rf_addr_b_i) && lsu_ctrl_valid_i &&
                        lsu_cmd_i[3] && (rf_addr_b_i != '0);

  // Multi-cycle states hold decode
  assign fsm_stall = (state_q == CTRL_LOAD0) || (state_q == CTRL_LOAD1) ||
                     (state_q == CTRL_JUMP0) || (state_q == CTRL_JUMP1);

  assign stall_o = rf_a_hazard || rf_b_hazard || lsu_b_hazard || fsm_stall;

  // Redirect to the fetch unit
  // Boot address in BOOT0, jump target in JUMP0
  assign jmp_addr_valid_o = (state_q == CTRL_BOOT0) || (state_q == CTRL_JUMP0);
  assign jmp_addr_o       = (state_q == CTRL_JUMP0) ? {alu_res_i[`RVJ1_XLEN-1:1], 1'b0}
                                                    : BOOT_ADDR;
  assign flush_o          = (state_q == CTRL_JUMP0);

  ////////////////////
  // Program counter
  ////////////////////

  always_ff @(posedge clk_i) begin
    if (!rstn_i) begin
      pc_q <= BOOT_ADDR;
    end else if (state_d == CTRL_JUMP1) begin
      pc_q <= alu_res_i;
    end else if ((instr_issued_i && !stall_o) || ctrl_jump_i) begin
      // Jump also steps, giving pc + 4 for the link register
      pc_q <= pc_q + `RVJ1_XLEN'(`RVJ1_ISTEP);
    end
  end

  assign program_counter_o = pc_q;

  ////////////////////
  // Branch condition
  ////////////////////

  // Type is latched with the branch, the result arrives one cycle later
  always_ff @(posedge clk_i) begin
    if (!rstn_i) begin
      branch_type_q <= BRANCH_EQ;
    end else if (ctrl_branch_i) begin
      branch_type_q <= ctrl_branch_type_i;
    end
  end

  // ALU gives a difference for EQ/NEQ, a set-less-than bit otherwise
  always_comb begin
    case (branch_type_q)
      BRANCH_EQ:  cond_met = (alu_res_i == '0);
      BRANCH_NEQ: cond_met = (alu_res_i != '0);
      BRANCH_LT:  cond_met = alu_res_i[0];
      BRANCH_GE:  cond_met = !alu_res_i[0];
      BRANCH_LTU: cond_met = alu_res_i[0];
      BRANCH_GEU: cond_met = !alu_res_i[0];
      default:    cond_met = 1'b0;
    endcase
  end

  ////////////////////
  // Controller FSM
  ////////////////////

  always_comb begin
    state_d = state_q;
    case (state_q)
      CTRL_RESET: state_d = CTRL_BOOT0;
      CTRL_BOOT0: state_d = CTRL_BOOT1;
      CTRL_BOOT1: state_d = CTRL_RUN;
      CTRL_RUN: begin
        // Branch wins over jump, jump over load
        if (ctrl_branch_i && !stall_o) begin
          state_d = CTRL_BRANCH;
        end else if (ctrl_jump_i && !stall_o) begin
          state_d = CTRL_JUMP0;
        end else if (lsu_ctrl_valid_i && !lsu_cmd_i[3] && !stall_o) begin
          state_d = CTRL_LOAD0;
        end
      end
      CTRL_LOAD0: state_d = CTRL_LOAD1;
      // Wait here for the LSU
      CTRL_LOAD1: begin
        if (lsu_ready_i) begin
          state_d = CTRL_RUN;
        end
      end
      CTRL_JUMP0: state_d = CTRL_JUMP1;
      CTRL_JUMP1: state_d = CTRL_RUN;
      CTRL_BRANCH: begin
        if (!stall_o) begin
          state_d = cond_met ? CTRL_JUMP0 : CTRL_RUN;
        end
      end
      default: state_d = CTRL_RESET;
    endcase
  end

  always_ff @(posedge clk_i) begin
    if (!rstn_i) begin
      state_q <= CTRL_RESET;
    end else begin
      state_q <= state_d;
    end
  end

endmodule

`default_nettype wire

// ==== source/rvj1_pkg.sv ====
`default_nettype none

`include "rvj1_defines.svh"

package rvj1_pkg;

  // LSU command, bit 3 marks a store
  // Bit 2 marks the unsigned load forms
  typedef enum logic [3:0] {
    LSU_LB  = 4'b0000,
    LSU_LH  = 4'b0001,
    LSU_LW  = 4'b0010,
    LSU_LBU = 4'b0100,
    LSU_LHU = 4'b0101,
    LSU_SB  = 4'b1000,
    LSU_SH  = 4'b1001,
    LSU_SW  = 4'b1010
  } lsu_ctrl_e;

  // Branch type, follows the funct3 field of the branch opcodes
  typedef enum logic [2:0] {
    BRANCH_EQ  = 3'b000,
    BRANCH_NEQ = 3'b001,
    BRANCH_LT  = 3'b100,
    BRANCH_GE  = 3'b101,
    BRANCH_LTU = 3'b110,
    BRANCH_GEU = 3'b111
  } branch_ctrl_e;

  // Controller states
  typedef enum logic [3:0] {
    CTRL_RESET, CTRL_BOOT0, CTRL_BOOT1, CTRL_JUMP0, CTRL_JUMP1,
    CTRL_RUN, CTRL_LOAD0, CTRL_LOAD1, CTRL_BRANCH
  } ctrl_fsm_e;

endpackage

`default_nettype wire

// ==== source/rvj1_defines.svh ====
`ifndef RVJ1_DEFINES_SVH
`define RVJ1_DEFINES_SVH

// Data path and address width
`define RVJ1_XLEN 32

// Register file address width, 32 registers
`define RVJ1_RALEN 5

// Reset vector of the core
`define RVJ1_BOOT_ADDR 32'h8000_0000

// Program counter step per instruction
`define RVJ1_ISTEP 4

`endif
